//--- dv/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic reset
);
    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;    // 10 ns period
    end

    initial
    begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- dv/fetch_testdata.txt
# M addr data : memory word, other words read as the inverted address
# E cnt dly kind a b : event after cnt transfers plus dly cycles, kinds 1 csr 2 refetch
#   3 ex 4 ertn 5 branch 6 branch+refetch 7 crit_change 8 allowin mode 9 latency min max
# F cnt dly idx vppn ps g asid ppn plv mat d v : tlb fill
# X pc inst exc rn : expected bundle, exc is {tlbr,pif,ppi,adef}
M 1C000000 02800C0C
M 1C000004 028004A5
M 1C000008 0015000D
M 1C00000C 4C000020
E 0 0 9 0 0
F 0 0 0 200 0 1 0 1C010 3 1 0 1
F 0 1 1 300 0 1 0 1C020 3 1 0 0
F 0 2 2 400 0 1 0 1C030 0 1 0 1
F 0 3 3 600 1 1 0 1C400 3 1 0 1
E 0 4 8 1 0
E 4 0 8 2 0
E 4 0 9 0 4
E 10 0 5 0 1C000100
E 12 1 5 0 1C000200
E 14 1 3 0 1C000300
E 16 0 4 0 1C000400
E 18 1 6 1C000600 1C000500
E 20 0 1 2 A0000001
E 20 0 1 0 10
E 20 0 4 0 BC000010
E 22 0 4 0 00400FF8
E 25 0 3 0 00200000
E 27 0 3 0 00600000
E 28 0 1 0 13
E 28 0 3 0 00800000
E 29 0 3 0 00C12340
E 30 0 1 0 8
E 30 0 3 0 1C000102
E 31 0 2 0 1C000700
E 31 0 7 1 0
E 32 0 7 0 0
X 1C000000 02800C0C 0 0
X 1C000004 028004A5 0 0
X 1C000008 0015000D 0 0
X 1C00000C 4C000020 0 0
X 1C000010 E3FFFFEF 0 0
X 1C000014 E3FFFFEB 0 0
X 1C000018 E3FFFFE7 0 0
X 1C00001C E3FFFFE3 0 0
X 1C000020 E3FFFFDF 0 0
X 1C000024 E3FFFFDB 0 0
X 1C000100 E3FFFEFF 0 0
X 1C000104 E3FFFEFB 0 0
X 1C000200 E3FFFDFF 0 0
X 1C000204 E3FFFDFB 0 0
X 1C000300 E3FFFCFF 0 0
X 1C000304 E3FFFCFB 0 0
X 1C000400 E3FFFBFF 0 0
X 1C000404 E3FFFBFB 0 0
X 1C000500 E3FFFAFF 0 0
X 1C000504 E3FFFAFB 0 0
X BC000010 E3FFFFEF 0 0
X BC000014 E3FFFFEB 0 0
X 00400FF8 E3FEF007 0 0
X 00400FFC E3FEF003 0 0
X 00401000 E3FEEFFF 0 0
X 00200000 00000000 8 0
X 00200004 00000000 8 0
X 00600000 00000000 4 0
X 00800000 00000000 2 0
X 00C12340 E3BEDCBF 0 0
X 1C000102 00000000 1 0
X 1C000700 E3FFF8FF 0 1
X 1C000704 E3FFF8FB 0 0

//--- dv/inst_sram_model.sv
`timescale 1ns/1ps

module inst_sram_model (
    input  logic                  clk,
    input  logic                  reset,
    input  fetch_pkg::isram_req_t isram,
    input  logic [31:0]           lat_min,
    input  logic [31:0]           lat_max,
    output logic [31:0]           rdata,
    output logic                  addr_ok,
    output logic                  data_ok
);
    logic [31:0] image [logic [31:0]];    // words loaded from the test data
    logic        busy;
    logic [31:0] wait_cnt;
    logic [31:0] word_q;

    // unloaded words read back as the inverted word address
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] waddr;
        waddr = {addr[31:2], 2'b00};
        if (image.exists(waddr))
            return image[waddr];
        return ~waddr;
    endfunction

    initial
    begin
        int          fd;
        string       line;
        logic [31:0] a;
        logic [31:0] d;
        fd = $fopen("dv/fetch_testdata.txt", "r");
        if (fd != 0)
        begin
            while ($fgets(line, fd) > 0)
            begin
                if ($sscanf(line, "M %h %h", a, d) == 2)
                    image[a] = d;
            end
            $fclose(fd);
        end
    end

    assign addr_ok = ~busy;    // one outstanding request
    assign data_ok = busy & (wait_cnt == 32'd0);
    assign rdata   = data_ok ? word_q : ~word_q;    // only meaningful with data_ok

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy   <= 1'b0;
            word_q <= '0;
        end
        else if (isram.req & addr_ok)
        begin
            busy     <= 1'b1;
            wait_cnt <= lat_min + ($urandom % (lat_max - lat_min + 32'd1));
            word_q   <= read_word(isram.addr);
        end
        else if (busy)
        begin
            if (wait_cnt == 32'd0)
                busy <= 1'b0;
            else
                wait_cnt <= wait_cnt - 32'd1;
        end
    end

endmodule

//--- dv/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;
    import mmu_pkg::*;
    import fetch_pkg::*;

    typedef struct packed {
        logic [31:0] cnt;     // transfers seen before the event
        logic [31:0] dly;     // cycles after that transfer
        logic [3:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        tlb_entry_t  ent;
    } stim_event_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [3:0]  exc;
        logic        rn;
    } expect_t;

    logic        clk;
    logic        reset;
    logic        ds_allowin;
    br_bus_t     br;
    redirect_t   redirect;
    csr_view_t   csr;
    logic        crit_change;
    tlb_fill_t   tlb_fill;
    logic        fs_to_ds_valid;
    fs_to_ds_t   fs_to_ds;
    isram_req_t  isram;
    logic [31:0] isram_rdata;
    logic        isram_addr_ok;
    logic        isram_data_ok;
    logic [31:0] lat_min;
    logic [31:0] lat_max;

    stim_event_t events[$];
    expect_t     expected[$];
    expect_t     exp_b;
    int          ev_ptr;
    int          n_done;
    int          last_done;
    int          since;
    int          cycles;
    int          limit;
    int          allow_mode;    // 0 low, 1 high, 2 random
    int          seed_init;

    clk_gen u_clk_gen (.clk(clk), .reset(reset));

    fetch_top u_dut (
        .clk(clk), .reset(reset), .ds_allowin(ds_allowin), .br(br),
        .redirect(redirect), .csr(csr), .crit_change(crit_change),
        .tlb_fill(tlb_fill), .fs_to_ds_valid(fs_to_ds_valid), .fs_to_ds(fs_to_ds),
        .isram(isram), .isram_rdata(isram_rdata), .isram_addr_ok(isram_addr_ok),
        .isram_data_ok(isram_data_ok)
    );

    inst_sram_model u_mem (
        .clk(clk), .reset(reset), .isram(isram), .lat_min(lat_min), .lat_max(lat_max),
        .rdata(isram_rdata), .addr_ok(isram_addr_ok), .data_ok(isram_data_ok)
    );

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("Mismatch %s: got %h expected %h (bundle %0d)", name, got, exp, n_done);
            $display("TEST FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic read_testdata();
        int          fd;
        string       line;
        logic [31:0] f [12];
        stim_event_t ev;
        expect_t     ex;
        fd = $fopen("dv/fetch_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the test data file");
            $display("TEST FAILED");
            $fatal(1, "no test data");
        end
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                ev = '0;
                if ($sscanf(line, "E %d %d %h %h %h", f[0], f[1], f[2], f[3], f[4]) == 5)
                begin
                    ev.cnt  = f[0];
                    ev.dly  = f[1];
                    ev.kind = f[2][3:0];
                    ev.a    = f[3];
                    ev.b    = f[4];
                    events.push_back(ev);
                end
                else if ($sscanf(line, "F %d %d %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
                                 f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                                 f[11]) == 12)
                begin
                    ev.cnt       = f[0];
                    ev.dly       = f[1];
                    ev.kind      = 4'hA;
                    ev.a         = f[2];
                    ev.ent.vppn  = f[3][18:0];
                    ev.ent.ps4mb = f[4][0];
                    ev.ent.g     = f[5][0];
                    ev.ent.asid  = f[6][9:0];
                    ev.ent.ppn   = f[7][19:0];
                    ev.ent.plv   = f[8][1:0];
                    ev.ent.mat   = f[9][1:0];
                    ev.ent.d     = f[10][0];
                    ev.ent.v     = f[11][0];
                    events.push_back(ev);
                end
                else if ($sscanf(line, "X %h %h %h %h", f[0], f[1], f[2], f[3]) == 4)
                begin
                    ex.pc   = f[0];
                    ex.inst = f[1];
                    ex.exc  = f[2][3:0];
                    ex.rn   = f[3][0];
                    expected.push_back(ex);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_event(input stim_event_t ev);
        case (ev.kind)
            4'h1:
            begin
                case (ev.a[1:0])
                    2'd0: csr.crmd = ev.b;
                    2'd1: csr.asid = ev.b;
                    2'd2: csr.dmw0 = ev.b;
                    default: csr.dmw1 = ev.b;
                endcase
            end
            4'h2: redirect = '{refetch: 1'b1, ex: 1'b0, ertn: 1'b0, target: ev.b};
            4'h3: redirect = '{refetch: 1'b0, ex: 1'b1, ertn: 1'b0, target: ev.b};
            4'h4: redirect = '{refetch: 1'b0, ex: 1'b0, ertn: 1'b1, target: ev.b};
            4'h5: br = '{stall: 1'b0, taken: 1'b1, target: ev.b};
            4'h6:
            begin
                br       = '{stall: 1'b0, taken: 1'b1, target: ev.a};
                redirect = '{refetch: 1'b1, ex: 1'b0, ertn: 1'b0, target: ev.b};
            end
            4'h7: crit_change = ev.a[0];
            4'h8: allow_mode = ev.a;
            4'h9:
            begin
                lat_min = ev.a;
                lat_max = ev.b;
            end
            default: tlb_fill = '{we: 1'b1, idx: ev.a[TLB_IDX_W-1:0], entry: ev.ent};
        endcase
    endtask

    initial
    begin
        int max_lat;
        seed_init   = $urandom(77);
        ds_allowin  = 1'b0;
        br          = '0;
        redirect    = '0;
        csr         = '0;
        csr.crmd.da = 1'b1;    // direct address mode out of reset
        crit_change = 1'b0;
        tlb_fill    = '0;
        lat_min     = 32'd0;
        lat_max     = 32'd0;
        allow_mode  = 0;
        ev_ptr      = 0;
        n_done      = 0;
        last_done   = 0;
        since       = 0;
        cycles      = 0;
        read_testdata();
        max_lat = 0;
        limit   = 200;
        foreach (events[i])
        begin
            limit += int'(events[i].dly);
            if (events[i].kind == 4'h9 && int'(events[i].b) > max_lat)
                max_lat = int'(events[i].b);
        end
        limit += expected.size() * (max_lat + 2) * 4;
    end

    // stimulus on the falling edge
    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (n_done != last_done)
            begin
                last_done = n_done;
                since     = 0;
            end
            br          = '0;
            redirect    = '0;
            tlb_fill.we = 1'b0;
            while (ev_ptr < events.size() &&
                   (int'(events[ev_ptr].cnt) < n_done ||
                    (int'(events[ev_ptr].cnt) == n_done && int'(events[ev_ptr].dly) <= since)))
            begin
                apply_event(events[ev_ptr]);
                ev_ptr++;
            end
            if (allow_mode == 2)
                ds_allowin = 1'($urandom & 1);
            else
                ds_allowin = (allow_mode == 1);
            since++;
        end
    end

    always @(posedge clk)
    begin
        if (!reset)
        begin
            cycles++;
            if (fs_to_ds_valid && ds_allowin)
            begin
                exp_b = expected[n_done];
                compare_value("fs_to_ds.pc", fs_to_ds.pc, exp_b.pc);
                compare_value("fs_to_ds.inst", fs_to_ds.inst, exp_b.inst);
                compare_value("fs_to_ds.exc", {28'd0, fs_to_ds.exc}, {28'd0, exp_b.exc});
                compare_value("fs_to_ds.refetch_needed", {31'd0, fs_to_ds.refetch_needed},
                              {31'd0, exp_b.rn});
                n_done++;
            end
            if (cycles >= limit)
            begin
                $display("timeout after %0d cycles with %0d of %0d bundles seen",
                         cycles, n_done, expected.size());
                $display("TEST FAILED");
                $fatal(1, "timeout");
            end
            else if (n_done == expected.size())
            begin
                $display("TEST OK");
                $finish;
            end
        end
    end

endmodule

//--- flist.f
src/mmu_pkg.sv
src/fetch_pkg.sv
src/addr_translator.sv
src/itlb.sv
src/fetch_stage.sv
src/fetch_top.sv
dv/clk_gen.sv
dv/inst_sram_model.sv
dv/tb_fetch.sv

//--- run.sh
#!/bin/sh
# build and run the fetch testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_fetch -f flist.f \
    -o sim_fetch > build.log 2>&1 &&
./obj_dir/sim_fetch > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- src/addr_translator.sv
`timescale 1ns/1ps

module addr_translator (
    input  logic [31:0]        vaddr,
    input  mmu_pkg::csr_view_t csr,
    output logic               use_page_table,
    output logic [31:0]        paddr
);
    import mmu_pkg::*;

    logic paging;
    logic hit0;
    logic hit1;

    // window applies only at the privilege levels it enables
    function automatic logic dmw_match(
        input dmw_t       w,
        input logic [1:0] plv,
        input logic [2:0] seg
    );
        logic plv_ok;
        plv_ok = (plv == 2'd0 && w.plv0) || (plv == 2'd3 && w.plv3);
        return plv_ok && (w.vseg == seg);
    endfunction

    assign paging = ~csr.crmd.da & csr.crmd.pg;

    assign hit0 = paging & dmw_match(csr.dmw0, csr.crmd.plv, vaddr[31:29]);
    assign hit1 = paging & dmw_match(csr.dmw1, csr.crmd.plv, vaddr[31:29]);

    assign use_page_table = paging & ~hit0 & ~hit1;

    always_comb
    begin
        if (hit0)                 // dmw0 wins when both hit
            paddr = {csr.dmw0.pseg, vaddr[28:0]};
        else if (hit1)
            paddr = {csr.dmw1.pseg, vaddr[28:0]};
        else
            paddr = vaddr;        // direct mode, or unused when the tlb maps
    end

endmodule

//--- src/fetch_pkg.sv
package fetch_pkg;

    // branch resolution from decode
    typedef struct packed {
        logic        stall;    // branch not resolved yet, hold requests
        logic        taken;
        logic [31:0] target;
    } br_bus_t;

    // writeback redirect; target already picked upstream
    // as refetch pc, exception entry or era
    typedef struct packed {
        logic        refetch;
        logic        ex;
        logic        ertn;
        logic [31:0] target;
    } redirect_t;

    // read-only instruction sram request
    typedef struct packed {
        logic        req;
        logic [31:0] addr;
    } isram_req_t;

    typedef struct packed {
        logic tlbr;   // tlb refill
        logic pif;    // page invalid on fetch
        logic ppi;    // privilege violation
        logic adef;   // misaligned fetch address
    } fetch_exc_t;

    // 4 + 1 + 32 + 32 = 69 bits
    typedef struct packed {
        fetch_exc_t  exc;
        logic        refetch_needed;
        logic [31:0] inst;
        logic [31:0] pc;
    } fs_to_ds_t;

endpackage

//--- src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter logic [31:0] RESET_PC = 32'h1C000000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ds_allowin,
    input  fetch_pkg::br_bus_t    br,
    input  fetch_pkg::redirect_t  redirect,
    input  mmu_pkg::csr_view_t    csr,
    input  logic                  crit_change,
    output logic                  fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t  fs_to_ds,
    output fetch_pkg::isram_req_t isram,
    input  logic [31:0]           isram_rdata,
    input  logic                  isram_addr_ok,
    input  logic                  isram_data_ok,
    output logic [31:0]           tlb_vaddr,
    input  logic                  use_page_table,
    input  logic [31:0]           direct_paddr,
    input  mmu_pkg::tlb_lookup_t  tlb
);
    import fetch_pkg::*;

    // one-hot state bit positions
    localparam int I_ACCEPT       = 0;  // wait for addr_ok, sequential pc
    localparam int I_DATA         = 1;  // wait for data or decode
    localparam int I_DATA_BR      = 2;  // same, for a redirect target
    localparam int I_ACCEPT_REDIR = 3;  // request the captured target
    localparam int I_DROP         = 4;  // swallow a stale response

    logic [4:0]  state;
    logic [4:0]  state_next;
    logic [31:0] fs_pc;
    logic [31:0] seq_pc;
    logic [31:0] nextpc;
    logic [31:0] nextpc_r;
    logic [31:0] inst_buf;
    logic        buf_valid;
    logic        fs_valid;
    fetch_exc_t  exc_now;
    fetch_exc_t  exc_r;
    logic        wb_redir;
    logic        br_taken;
    logic        br_hit;
    logic        flush;
    logic        handshake;
    logic        fs_ready_go;
    logic        transfer;

    function automatic logic [4:0] st(input int idx);
        return 5'b00001 << idx;
    endfunction

    assign wb_redir = redirect.refetch | redirect.ex | redirect.ertn;
    assign br_taken = br.taken & ~br.stall;
    // after a redirect the branch bus still shows the old branch until the target moves on
    assign br_hit   = br_taken & (state[I_ACCEPT] | state[I_DATA]);
    assign flush    = wb_redir | br_hit;

    assign seq_pc = fs_pc + 32'd4;

    // writeback redirect beats a captured target, which beats a branch
    always_comb
    begin
        if (wb_redir)
            nextpc = redirect.target;
        else if (state[I_ACCEPT_REDIR] | state[I_DROP])
            nextpc = nextpc_r;
        else if (br_hit)
            nextpc = br.target;
        else
            nextpc = seq_pc;
    end

    assign tlb_vaddr = nextpc;

    always_comb
    begin
        isram.req  = (state[I_ACCEPT] & (~br.stall | wb_redir)) | state[I_ACCEPT_REDIR];
        isram.addr = use_page_table ? {tlb.ppn, nextpc[11:0]} : direct_paddr;
    end

    assign handshake = isram.req & isram_addr_ok;

    always_comb
    begin
        exc_now.adef = |nextpc[1:0];
        exc_now.tlbr = use_page_table & ~tlb.found;
        exc_now.pif  = use_page_table & tlb.found & ~tlb.v;
        exc_now.ppi  = use_page_table & tlb.found & tlb.v & (csr.crmd.plv > tlb.plv);
    end

    assign fs_ready_go    = isram_data_ok | buf_valid;
    assign fs_to_ds_valid = fs_valid & fs_ready_go & ~flush;
    assign transfer       = fs_to_ds_valid & ds_allowin;

    always_comb
    begin
        fs_to_ds.exc            = exc_r;
        fs_to_ds.refetch_needed = crit_change;
        fs_to_ds.pc             = fs_pc;
        if (exc_r != '0)
            fs_to_ds.inst = 32'h0;    // faulting fetch carries no instruction
        else
            fs_to_ds.inst = buf_valid ? inst_buf : isram_rdata;
    end

    always_comb
    begin
        state_next = state;
        if (state[I_ACCEPT])
        begin
            if (handshake)
                state_next = flush ? st(I_DATA_BR) : st(I_DATA);
            else if (flush)
                state_next = st(I_ACCEPT_REDIR);
        end
        else if (state[I_ACCEPT_REDIR])
        begin
            if (handshake)
                state_next = st(I_DATA_BR);
        end
        else if (state[I_DATA] | state[I_DATA_BR])
        begin
            if (flush)    // response still out means it must be dropped
                state_next = fs_ready_go ? st(I_ACCEPT_REDIR) : st(I_DROP);
            else if (transfer)
                state_next = st(I_ACCEPT);
        end
        else
        begin
            if (isram_data_ok)
                state_next = st(I_ACCEPT_REDIR);
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= st(I_ACCEPT);
            fs_pc     <= RESET_PC - 32'd4;   // first request goes to RESET_PC
            fs_valid  <= 1'b0;
            buf_valid <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (handshake)
                fs_pc <= nextpc;

            if (handshake)
                fs_valid <= 1'b1;
            else if (flush | transfer)
                fs_valid <= 1'b0;

            if (flush | transfer)
                buf_valid <= 1'b0;
            else if (fs_valid & isram_data_ok)
                buf_valid <= 1'b1;    // decode not ready, hold it
        end
    end

    always_ff @(posedge clk)
    begin
        nextpc_r <= nextpc;    // keeps the target while waiting
        if (handshake)
            exc_r <= exc_now;
        if (isram_data_ok)
            inst_buf <= isram_rdata;
    end

endmodule

//--- src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter int          TLB_ENTRIES = 16,
    parameter logic [31:0] RESET_PC    = 32'h1C000000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ds_allowin,
    input  fetch_pkg::br_bus_t    br,
    input  fetch_pkg::redirect_t  redirect,
    input  mmu_pkg::csr_view_t    csr,
    input  logic                  crit_change,
    input  mmu_pkg::tlb_fill_t    tlb_fill,
    output logic                  fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t  fs_to_ds,
    output fetch_pkg::isram_req_t isram,
    input  logic [31:0]           isram_rdata,
    input  logic                  isram_addr_ok,
    input  logic                  isram_data_ok
);
    import mmu_pkg::*;

    logic [31:0] fetch_vaddr;     // next pc, translated combinationally
    logic [31:0] direct_paddr;
    logic        use_page_table;
    tlb_lookup_t tlb_result;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch_stage (
        .clk            (clk),
        .reset          (reset),
        .ds_allowin     (ds_allowin),
        .br             (br),
        .redirect       (redirect),
        .csr            (csr),
        .crit_change    (crit_change),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .isram          (isram),
        .isram_rdata    (isram_rdata),
        .isram_addr_ok  (isram_addr_ok),
        .isram_data_ok  (isram_data_ok),
        .tlb_vaddr      (fetch_vaddr),
        .use_page_table (use_page_table),
        .direct_paddr   (direct_paddr),
        .tlb            (tlb_result)
    );

    addr_translator u_addr_translator (
        .vaddr          (fetch_vaddr),
        .csr            (csr),
        .use_page_table (use_page_table),
        .paddr          (direct_paddr)
    );

    itlb #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_itlb (
        .clk    (clk),
        .reset  (reset),
        .fill   (tlb_fill),
        .asid   (csr.asid.asid),
        .vaddr  (fetch_vaddr),
        .result (tlb_result)
    );

endmodule

//--- src/itlb.sv
`timescale 1ns/1ps

module itlb #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                 clk,
    input  logic                 reset,
    input  mmu_pkg::tlb_fill_t   fill,
    input  logic [9:0]           asid,
    input  logic [31:0]          vaddr,
    output mmu_pkg::tlb_lookup_t result
);
    import mmu_pkg::*;

    localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    tlb_entry_t             entry [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] present;    // slot holds a filled entry
    logic [TLB_ENTRIES-1:0] match;
    logic                   hit_found;
    logic [IDX_W-1:0]       hit_idx;
    tlb_entry_t             sel;

    always_ff @(posedge clk)
    begin
        if (fill.we)
            entry[fill.idx[IDX_W-1:0]] <= fill.entry;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            present <= '0;
        else if (fill.we)
            present[fill.idx[IDX_W-1:0]] <= 1'b1;
    end

    for (genvar i = 0; i < TLB_ENTRIES; i++)
    begin : g_match
        logic asid_ok;
        logic vpn_ok;

        assign asid_ok = entry[i].g | (entry[i].asid == asid);
        // 4 MB pages compare only vaddr[31:22]
        assign vpn_ok  = entry[i].ps4mb ? (entry[i].vppn[18:9] == vaddr[31:22])
                                        : (entry[i].vppn == vaddr[31:13]);
        assign match[i] = present[i] & asid_ok & vpn_ok;
    end

    // lowest matching slot wins
    always_comb
    begin
        hit_found = 1'b0;
        hit_idx   = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--)
        begin
            if (match[i])
            begin
                hit_found = 1'b1;
                hit_idx   = IDX_W'(i);
            end
        end
    end

    always_comb
    begin
        sel    = entry[hit_idx];
        result = '0;
        if (hit_found)
        begin
            result.found = 1'b1;
            result.ps4mb = sel.ps4mb;
            result.plv   = sel.plv;
            result.v     = sel.v;
            // 4 KB entries map the even/odd page pair onto an aligned 8 KB frame
            if (sel.ps4mb)
                result.ppn = {sel.ppn[19:10], vaddr[21:12]};
            else
                result.ppn = {sel.ppn[19:1], vaddr[12]};
        end
    end

endmodule

//--- src/mmu_pkg.sv
package mmu_pkg;

    // crmd; fetch only looks at plv, da and pg
    typedef struct packed {
        logic [22:0] rsv;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;     // paged translation
        logic        da;     // direct address mode
        logic        ie;
        logic [1:0]  plv;    // current privilege level
    } crmd_t;

    typedef struct packed {
        logic [7:0] rsv_hi;
        logic [7:0] asidbits;
        logic [5:0] rsv_lo;
        logic [9:0] asid;
    } asid_t;

    // direct-map window
    typedef struct packed {
        logic [2:0]  vseg;    // matched against vaddr[31:29]
        logic        rsv_28;
        logic [2:0]  pseg;    // replaces the segment on a hit
        logic [18:0] rsv_mid;
        logic [1:0]  mat;
        logic        plv3;
        logic [1:0]  rsv_lo;
        logic        plv0;
    } dmw_t;

    typedef struct packed {
        crmd_t crmd;
        asid_t asid;
        dmw_t  dmw0;
        dmw_t  dmw1;
    } csr_view_t;

    localparam int TLB_IDX_W = 5;   // fill index, covers up to 32 entries

    typedef struct packed {
        logic [18:0] vppn;   // vaddr[31:13]
        logic        ps4mb;  // 0: 4 KB page pair, 1: 4 MB page
        logic        g;
        logic [9:0]  asid;
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } tlb_entry_t;

    typedef struct packed {
        logic                 we;
        logic [TLB_IDX_W-1:0] idx;
        tlb_entry_t           entry;
    } tlb_fill_t;

    typedef struct packed {
        logic        found;
        logic [19:0] ppn;    // already merged with the low vaddr bits
        logic        ps4mb;
        logic [1:0]  plv;
        logic        v;
    } tlb_lookup_t;

endpackage
